// File: bridge_consts.svh
// bridge constants
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

`default_nettype none

// ----------------------------------------------------------------------
// bus geometry
// ----------------------------------------------------------------------

// byte address width on the core port and on AW/AR
`define BR_ADDR_W 32

// AXI data bus width, two 32-bit lanes
`define BR_AXI_DW 64

// AXI id width, ids are constant per direction
`define BR_ID_W 4

// ----------------------------------------------------------------------
// memory slave
// ----------------------------------------------------------------------

// depth in 64-bit words, addresses wrap beyond this
`define BR_MEM_WORDS 256

`default_nettype wire

`endif

// File: axi_pkg.sv
// AXI4 channel types
`include "bridge_consts.svh"
`default_nettype none

package axi_pkg;

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------

  // response code on B and R
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // burst type on AW and AR, only INCR is issued
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------

  // write address
  typedef struct packed {
    logic [`BR_ID_W-1:0]   id;
    logic [`BR_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_aw_t;

  // write data, one strobe bit per byte
  typedef struct packed {
    logic [`BR_AXI_DW-1:0]   data;
    logic [`BR_AXI_DW/8-1:0] strb;
    logic                    last;
  } axi_w_t;

  // write response
  typedef struct packed {
    logic [`BR_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  // read address, same fields as AW
  typedef struct packed {
    logic [`BR_ID_W-1:0]   id;
    logic [`BR_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_ar_t;

  // read data
  typedef struct packed {
    logic [`BR_ID_W-1:0]   id;
    logic [`BR_AXI_DW-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: core_mem_pkg.sv
// core port and FSM types
`include "bridge_consts.svh"
`default_nettype none

package core_mem_pkg;

  // core data port request, held by the core until gnt
  typedef struct packed {
    logic [`BR_ADDR_W-1:0] addr;
    logic                  we;
    logic [3:0]            be;
    logic [31:0]           wdata;
  } core_req_t;

  // ----------------------------------------------------------------------
  // state encodings
  // ----------------------------------------------------------------------

  // bridge FSM
  // WRITE_DATA means AW went out first, WRITE_ADDR means W went out first
  typedef enum logic [2:0] {
    BR_IDLE,
    BR_WRITE_DATA,
    BR_WRITE_ADDR,
    BR_WRITE_WAIT,
    BR_READ_WAIT
  } bridge_state_e;

  // memory slave FSM
  typedef enum logic [1:0] {
    SL_IDLE,
    SL_WRITE_COLLECT,
    SL_WRITE_RESP,
    SL_READ_RESP
  } slave_state_e;

endpackage

`default_nettype wire

// File: core_axi_bridge.sv
// core to AXI4 bridge
`include "bridge_consts.svh"
`default_nettype none

module core_axi_bridge (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core data port
  input  logic                    data_req_i,
  input  core_mem_pkg::core_req_t data_i,
  output logic                    data_gnt_o,
  output logic                    data_rvalid_o,
  output logic [31:0]             data_rdata_o,
  // write address
  output axi_pkg::axi_aw_t        aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  // write data
  output axi_pkg::axi_w_t         w_o,
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  // write response
  input  axi_pkg::axi_b_t         b_i,
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  // read address
  output axi_pkg::axi_ar_t        ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  // read data
  input  axi_pkg::axi_r_t         r_i,
  input  logic                    r_valid_i,
  output logic                    r_ready_o
);

  // constant ids, one per direction
  localparam logic [`BR_ID_W-1:0] AW_ID = `BR_ID_W'd0;
  localparam logic [`BR_ID_W-1:0] AR_ID = `BR_ID_W'd5;

  // 4-byte transfers on the 8-byte bus
  localparam logic [2:0] SIZE_WORD = 3'b010;

  core_mem_pkg::bridge_state_e state_q;
  core_mem_pkg::bridge_state_e state_d;

  // lane of the granted request, picks the read half
  logic lane_q;

  // ----------------------------------------------------------------------
  // main FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d       = state_q;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    aw_valid_o    = 1'b0;
    w_valid_o     = 1'b0;
    ar_valid_o    = 1'b0;
    b_ready_o     = 1'b0;
    r_ready_o     = 1'b0;

    unique case (state_q)
      core_mem_pkg::BR_IDLE: begin
        if (data_req_i && data_i.we) begin
          // offer AW and W together
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (aw_ready_i && w_ready_i) begin
            data_gnt_o = 1'b1;
            state_d    = core_mem_pkg::BR_WRITE_WAIT;
          end else if (aw_ready_i) begin
            state_d = core_mem_pkg::BR_WRITE_DATA;
          end else if (w_ready_i) begin
            state_d = core_mem_pkg::BR_WRITE_ADDR;
          end
        end else if (data_req_i) begin
          ar_valid_o = 1'b1;
          if (ar_ready_i) begin
            data_gnt_o = 1'b1;
            state_d    = core_mem_pkg::BR_READ_WAIT;
          end
        end
      end

      // address taken, data still pending
      core_mem_pkg::BR_WRITE_DATA: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          data_gnt_o = 1'b1;
          state_d    = core_mem_pkg::BR_WRITE_WAIT;
        end
      end

      // data taken, address still pending
      core_mem_pkg::BR_WRITE_ADDR: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          data_gnt_o = 1'b1;
          state_d    = core_mem_pkg::BR_WRITE_WAIT;
        end
      end

      // rvalid rides on the B transfer
      core_mem_pkg::BR_WRITE_WAIT: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          data_rvalid_o = 1'b1;
          state_d       = core_mem_pkg::BR_IDLE;
        end
      end

      // rvalid rides on the R transfer
      core_mem_pkg::BR_READ_WAIT: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          data_rvalid_o = 1'b1;
          state_d       = core_mem_pkg::BR_IDLE;
        end
      end

      default: begin
        state_d = core_mem_pkg::BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= core_mem_pkg::BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // lane handling
  // ----------------------------------------------------------------------

  // capture address bit 2 with the grant
  always_ff @(posedge clk_i) begin
    if (data_gnt_o) begin
      lane_q <= data_i.addr[2];
    end
  end

  // upper half for bit 2 set
  assign data_rdata_o = lane_q ? r_i.data[63:32] : r_i.data[31:0];

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------

  assign aw_o = '{
    id:    AW_ID,
    addr:  data_i.addr,
    len:   8'd0,
    size:  SIZE_WORD,
    burst: axi_pkg::INCR
  };

  assign ar_o = '{
    id:    AR_ID,
    addr:  data_i.addr,
    len:   8'd0,
    size:  SIZE_WORD,
    burst: axi_pkg::INCR
  };

  // write data copied to both lanes, strobes pick the live one
  assign w_o = '{
    data: {2{data_i.wdata}},
    strb: data_i.addr[2] ? {data_i.be, 4'b0000} : {4'b0000, data_i.be},
    last: 1'b1
  };

endmodule

`default_nettype wire

// File: axi_chan_buffer.sv
// two-entry AXI channel buffer
`include "bridge_consts.svh"
`default_nettype none

module axi_chan_buffer #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // upstream side
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  // downstream side
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  // storage, no reset on payload
  logic [WIDTH-1:0] mem_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  logic push;
  logic pop;

  // full at two entries
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: axi_mem_slave.sv
// AXI4 word memory slave
`include "bridge_consts.svh"
`default_nettype none

module axi_mem_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  axi_pkg::axi_aw_t aw_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  axi_pkg::axi_w_t  w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output axi_pkg::axi_b_t  b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  input  axi_pkg::axi_ar_t ar_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  output axi_pkg::axi_r_t  r_o,
  output logic             r_valid_o,
  input  logic             r_ready_i
);

  localparam int unsigned IDX_W  = $clog2(`BR_MEM_WORDS);
  localparam int unsigned STRB_W = `BR_AXI_DW / 8;

  core_mem_pkg::slave_state_e state_q;
  core_mem_pkg::slave_state_e state_d;

  logic [`BR_AXI_DW-1:0] mem_q [`BR_MEM_WORDS];

  logic aw_fire;
  logic w_fire;
  logic ar_fire;

  // write halves already taken
  logic aw_got_q;
  logic w_got_q;

  logic [IDX_W-1:0]      aw_idx_q;
  logic [`BR_ID_W-1:0]   aw_id_q;
  axi_pkg::axi_w_t       w_q;
  logic [`BR_ID_W-1:0]   ar_id_q;
  logic [`BR_AXI_DW-1:0] rdata_q;

  // merged view of the write, from registers or straight from the channel
  logic            mem_we;
  logic [IDX_W-1:0] wr_idx;
  axi_pkg::axi_w_t wr_beat;

  // ----------------------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------------------

  // ready only while a valid is offered, so all readies idle low
  always_comb begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    unique case (state_q)
      core_mem_pkg::SL_IDLE: begin
        aw_ready_o = aw_valid_i;
        w_ready_o  = w_valid_i;
        // writes win, reads wait for a quiet write side
        ar_ready_o = ar_valid_i & ~aw_valid_i & ~w_valid_i;
      end
      core_mem_pkg::SL_WRITE_COLLECT: begin
        aw_ready_o = aw_valid_i & ~aw_got_q;
        w_ready_o  = w_valid_i & ~w_got_q;
      end
      default: begin
      end
    endcase
  end

  assign aw_fire = aw_valid_i & aw_ready_o;
  assign w_fire  = w_valid_i & w_ready_o;
  assign ar_fire = ar_valid_i & ar_ready_o;

  // commit once both halves are in, whichever came last
  assign mem_we  = (aw_got_q | aw_fire) & (w_got_q | w_fire);
  assign wr_idx  = aw_got_q ? aw_idx_q : aw_i.addr[3 +: IDX_W];
  assign wr_beat = w_got_q ? w_q : w_i;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      core_mem_pkg::SL_IDLE: begin
        if (mem_we) begin
          state_d = core_mem_pkg::SL_WRITE_RESP;
        end else if (aw_fire || w_fire) begin
          state_d = core_mem_pkg::SL_WRITE_COLLECT;
        end else if (ar_fire) begin
          state_d = core_mem_pkg::SL_READ_RESP;
        end
      end
      core_mem_pkg::SL_WRITE_COLLECT: begin
        if (mem_we) begin
          state_d = core_mem_pkg::SL_WRITE_RESP;
        end
      end
      // responses held until taken
      core_mem_pkg::SL_WRITE_RESP: begin
        if (b_ready_i) begin
          state_d = core_mem_pkg::SL_IDLE;
        end
      end
      core_mem_pkg::SL_READ_RESP: begin
        if (r_ready_i) begin
          state_d = core_mem_pkg::SL_IDLE;
        end
      end
      default: begin
        state_d = core_mem_pkg::SL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= core_mem_pkg::SL_IDLE;
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_we) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        aw_got_q <= aw_got_q | aw_fire;
        w_got_q  <= w_got_q | w_fire;
      end
    end
  end

  // ----------------------------------------------------------------------
  // payload and memory
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_idx_q <= aw_i.addr[3 +: IDX_W];
      aw_id_q  <= aw_i.id;
    end
    if (w_fire) begin
      w_q <= w_i;
    end
    if (ar_fire) begin
      ar_id_q <= ar_i.id;
      rdata_q <= mem_q[ar_i.addr[3 +: IDX_W]];
    end
    // byte merge under strobe
    if (mem_we) begin
      for (int unsigned i = 0; i < STRB_W; i++) begin
        if (wr_beat.strb[i]) begin
          mem_q[wr_idx][8*i +: 8] <= wr_beat.data[8*i +: 8];
        end
      end
    end
  end

  // always OKAY, single beat
  assign b_valid_o = (state_q == core_mem_pkg::SL_WRITE_RESP);
  assign b_o       = '{id: aw_id_q, resp: axi_pkg::OKAY};

  assign r_valid_o = (state_q == core_mem_pkg::SL_READ_RESP);
  assign r_o       = '{id: ar_id_q, data: rdata_q, resp: axi_pkg::OKAY, last: 1'b1};

endmodule

`default_nettype wire

// File: core_axi_sys.sv
// core to AXI memory system
`include "bridge_consts.svh"
`default_nettype none

module core_axi_sys (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    data_req_i,
  input  core_mem_pkg::core_req_t data_i,
  output logic                    data_gnt_o,
  output logic                    data_rvalid_o,
  output logic [31:0]             data_rdata_o
);

  // br_* faces the bridge, sl_* faces the slave
  axi_pkg::axi_aw_t br_aw, sl_aw;
  axi_pkg::axi_w_t  br_w, sl_w;
  axi_pkg::axi_b_t  br_b, sl_b;
  axi_pkg::axi_ar_t br_ar, sl_ar;
  axi_pkg::axi_r_t  br_r, sl_r;

  logic br_aw_valid, br_aw_ready, sl_aw_valid, sl_aw_ready;
  logic br_w_valid, br_w_ready, sl_w_valid, sl_w_ready;
  logic br_b_valid, br_b_ready, sl_b_valid, sl_b_ready;
  logic br_ar_valid, br_ar_ready, sl_ar_valid, sl_ar_ready;
  logic br_r_valid, br_r_ready, sl_r_valid, sl_r_ready;

  core_axi_bridge i_bridge (
    .clk_i, .rst_ni, .data_req_i, .data_i, .data_gnt_o, .data_rvalid_o, .data_rdata_o,
    .aw_o (br_aw), .aw_valid_o (br_aw_valid), .aw_ready_i (br_aw_ready),
    .w_o  (br_w),  .w_valid_o  (br_w_valid),  .w_ready_i  (br_w_ready),
    .b_i  (br_b),  .b_valid_i  (br_b_valid),  .b_ready_o  (br_b_ready),
    .ar_o (br_ar), .ar_valid_o (br_ar_valid), .ar_ready_i (br_ar_ready),
    .r_i  (br_r),  .r_valid_i  (br_r_valid),  .r_ready_o  (br_r_ready)
  );

  // ----------------------------------------------------------------------
  // request channels, bridge to slave
  // ----------------------------------------------------------------------

  axi_chan_buffer #(.WIDTH($bits(axi_pkg::axi_aw_t))) i_aw_buf (
    .clk_i, .rst_ni,
    .data_i (br_aw), .valid_i (br_aw_valid), .ready_o (br_aw_ready),
    .data_o (sl_aw), .valid_o (sl_aw_valid), .ready_i (sl_aw_ready)
  );

  axi_chan_buffer #(.WIDTH($bits(axi_pkg::axi_w_t))) i_w_buf (
    .clk_i, .rst_ni,
    .data_i (br_w), .valid_i (br_w_valid), .ready_o (br_w_ready),
    .data_o (sl_w), .valid_o (sl_w_valid), .ready_i (sl_w_ready)
  );

  axi_chan_buffer #(.WIDTH($bits(axi_pkg::axi_ar_t))) i_ar_buf (
    .clk_i, .rst_ni,
    .data_i (br_ar), .valid_i (br_ar_valid), .ready_o (br_ar_ready),
    .data_o (sl_ar), .valid_o (sl_ar_valid), .ready_i (sl_ar_ready)
  );

  // ----------------------------------------------------------------------
  // response channels, slave to bridge
  // ----------------------------------------------------------------------

  axi_chan_buffer #(.WIDTH($bits(axi_pkg::axi_b_t))) i_b_buf (
    .clk_i, .rst_ni,
    .data_i (sl_b), .valid_i (sl_b_valid), .ready_o (sl_b_ready),
    .data_o (br_b), .valid_o (br_b_valid), .ready_i (br_b_ready)
  );

  axi_chan_buffer #(.WIDTH($bits(axi_pkg::axi_r_t))) i_r_buf (
    .clk_i, .rst_ni,
    .data_i (sl_r), .valid_i (sl_r_valid), .ready_o (sl_r_ready),
    .data_o (br_r), .valid_o (br_r_valid), .ready_i (br_r_ready)
  );

  axi_mem_slave i_mem (
    .clk_i, .rst_ni,
    .aw_i (sl_aw), .aw_valid_i (sl_aw_valid), .aw_ready_o (sl_aw_ready),
    .w_i  (sl_w),  .w_valid_i  (sl_w_valid),  .w_ready_o  (sl_w_ready),
    .b_o  (sl_b),  .b_valid_o  (sl_b_valid),  .b_ready_i  (sl_b_ready),
    .ar_i (sl_ar), .ar_valid_i (sl_ar_valid), .ar_ready_o (sl_ar_ready),
    .r_o  (sl_r),  .r_valid_o  (sl_r_valid),  .r_ready_i  (sl_r_ready)
  );

endmodule

`default_nettype wire

// File: core_axi_assertions.sv
// core port and channel protocol assertions
`include "bridge_consts.svh"
`default_nettype none

module core_axi_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    data_req_i,
  input core_mem_pkg::core_req_t data_i,
  input logic                    data_gnt_o,
  input logic                    data_rvalid_o,
  // buffer outputs and the readies that drain them
  input logic                    sl_aw_valid,
  input logic                    sl_aw_ready,
  input logic                    sl_w_valid,
  input logic                    sl_w_ready,
  input logic                    sl_ar_valid,
  input logic                    sl_ar_ready,
  input logic                    br_b_valid,
  input logic                    br_b_ready,
  input logic                    br_r_valid,
  input logic                    br_r_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // set by a grant, cleared by its rvalid
  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (data_gnt_o) begin
      outstanding_q <= 1'b1;
    end else if (data_rvalid_o) begin
      outstanding_q <= 1'b0;
    end
  end

  property hold_valid(v, r);
    @(posedge clk_i) disable iff (!rst_ni) v && !r |=> v;
  endproperty

  // ----------------------------------------------------------------------
  // core port
  // ----------------------------------------------------------------------

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_i && !data_gnt_o |=> data_req_i && $stable(data_i))
    else begin
      fail_count++;
      $error("core request changed before its grant");
    end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_gnt_o |-> data_req_i)
    else begin
      fail_count++;
      $error("grant without a request");
    end

  a_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_rvalid_o |-> outstanding_q)
    else begin
      fail_count++;
      $error("rvalid without an outstanding grant");
    end

  // ----------------------------------------------------------------------
  // channel buffers hold valid until taken
  // ----------------------------------------------------------------------

  a_aw_hold: assert property (hold_valid(sl_aw_valid, sl_aw_ready))
    else begin
      fail_count++;
      $error("AW valid dropped before ready");
    end

  a_w_hold: assert property (hold_valid(sl_w_valid, sl_w_ready))
    else begin
      fail_count++;
      $error("W valid dropped before ready");
    end

  a_ar_hold: assert property (hold_valid(sl_ar_valid, sl_ar_ready))
    else begin
      fail_count++;
      $error("AR valid dropped before ready");
    end

  a_b_hold: assert property (hold_valid(br_b_valid, br_b_ready))
    else begin
      fail_count++;
      $error("B valid dropped before ready");
    end

  a_r_hold: assert property (hold_valid(br_r_valid, br_r_ready))
    else begin
      fail_count++;
      $error("R valid dropped before ready");
    end

endmodule

bind core_axi_sys core_axi_assertions u_assertions (.*);

`default_nettype wire

// File: tb_core_axi_sys.sv
// core to AXI system testbench
`include "bridge_consts.svh"
`default_nettype none

module tb_core_axi_sys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT   = 200;
  localparam int unsigned REF_WORDS = 2 * `BR_MEM_WORDS;
  localparam int unsigned REF_IDX_W = $clog2(REF_WORDS);

  // one entry per grant, in grant order
  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
  } expect_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    data_req_i;
  core_mem_pkg::core_req_t data_i;
  logic                    data_gnt_o;
  logic                    data_rvalid_o;
  logic [31:0]             data_rdata_o;

  // 32-bit image of the slave, two entries per 64-bit word
  logic [31:0] ref_mem [REF_WORDS];
  expect_t     pending [$];
  int unsigned outstanding;
  logic [31:0] lcg_state;

  core_axi_sys uut (
    .clk_i, .rst_ni, .data_req_i, .data_i, .data_gnt_o, .data_rvalid_o, .data_rdata_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  // wraps modulo the slave depth, bit 2 picks the lane
  function automatic logic [REF_IDX_W-1:0] ref_index(input logic [31:0] addr);
    return addr[2 +: REF_IDX_W];
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    return ref_mem[ref_index(addr)];
  endfunction

  function automatic void merge_write(input logic [31:0] addr, input logic [3:0] be,
                                      input logic [31:0] wdata);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[ref_index(addr)][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  // odd multiplier keeps every index distinct
  function automatic logic [31:0] fill_value(input int unsigned idx);
    return (idx * 32'h9e37_79b9) ^ 32'h6a09_e667;
  endfunction

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    end
  endtask

  // grants push, rvalid pops and compares, sampled mid-cycle
  always @(negedge clk_i) begin
    expect_t exp;
    if (rst_ni) begin
      if (data_rvalid_o) begin
        if (pending.size() == 0) begin
          stop_on_failure("rvalid arrived with no outstanding grant");
        end
        exp = pending.pop_front();
        outstanding--;
        if (exp.is_read) begin
          check_value("data_rdata_o", data_rdata_o, exp.data);
        end
      end
      if (data_req_i && data_gnt_o) begin
        // a second grant before rvalid breaks the single-outstanding rule
        check_value("outstanding at data_gnt_o", outstanding, 32'd0);
        if (data_i.we) begin
          merge_write(data_i.addr, data_i.be, data_i.wdata);
          pending.push_back('{is_read: 1'b0, data: 32'd0});
        end else begin
          pending.push_back('{is_read: 1'b1, data: expected_read(data_i.addr)});
        end
        outstanding++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  // req stays high into the next call, so calls in a row run back-to-back
  task automatic issue(input logic [31:0] addr, input logic we, input logic [3:0] be,
                       input logic [31:0] wdata);
    int unsigned cycles;
    cycles = 0;
    @(posedge clk_i);
    data_req_i <= 1'b1;
    data_i     <= '{addr: addr, we: we, be: be, wdata: wdata};
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_failure("timeout: a held request was never granted");
      end
    end while (!data_gnt_o);
  endtask

  task automatic drop_req();
    @(posedge clk_i);
    data_req_i <= 1'b0;
  endtask

  task automatic wait_quiet();
    int unsigned cycles;
    cycles = 0;
    while (outstanding != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_failure("timeout: a granted request never got its rvalid");
      end
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    rst_ni      = 1'b0;
    data_req_i  = 1'b0;
    data_i      = '0;
    outstanding = 0;
    lcg_state   = 32'h3d08_b665;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // idle bus after reset
    repeat (8) begin
      @(negedge clk_i);
      check_value("data_gnt_o", data_gnt_o, 32'd0);
      check_value("data_rvalid_o", data_rvalid_o, 32'd0);
    end

    // preload every lane of every word
    for (int unsigned i = 0; i < REF_WORDS; i++) begin
      issue(i * 4, 1'b1, 4'hf, fill_value(i));
    end
    drop_req();
    wait_quiet();

    // full words, lower then upper lane
    issue(32'h0000_0120, 1'b1, 4'hf, 32'hcafe_0001);
    issue(32'h0000_0120, 1'b0, 4'hf, 32'h0);
    issue(32'h0000_0124, 1'b1, 4'hf, 32'hbeef_0002);
    issue(32'h0000_0124, 1'b0, 4'hf, 32'h0);

    // single byte and half word merges
    issue(32'h0000_0040, 1'b1, 4'b0100, 32'h0011_2233);
    issue(32'h0000_0044, 1'b1, 4'b1100, 32'haabb_ccdd);
    issue(32'h0000_0048, 1'b1, 4'b0001, 32'h4455_6677);
    issue(32'h0000_0040, 1'b0, 4'hf, 32'h0);
    issue(32'h0000_0044, 1'b0, 4'hf, 32'h0);
    issue(32'h0000_0048, 1'b0, 4'hf, 32'h0);

    // aliasing one memory depth apart
    issue(32'h0000_0208 + (`BR_MEM_WORDS * 8), 1'b1, 4'hf, 32'h5151_a0a0);
    issue(32'h0000_0208, 1'b0, 4'hf, 32'h0);
    issue(32'h0000_020c, 1'b1, 4'b0011, 32'h1234_9876);
    issue(32'h0000_020c + (2 * `BR_MEM_WORDS * 8), 1'b0, 4'hf, 32'h0);
    drop_req();
    wait_quiet();

    // random mix, mostly back-to-back with an idle gap now and then
    repeat (300) begin
      rnd  = next_random();
      addr = next_random() & 32'hffff_fffc;
      issue(addr, rnd[31], rnd[27:24], next_random());
      if (rnd[19:18] == 2'b00) begin
        drop_req();
        wait_quiet();
      end
    end
    drop_req();
    wait_quiet();
    repeat (4) @(posedge clk_i);

    if (uut.u_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
axi_pkg.sv
core_mem_pkg.sv
core_axi_bridge.sv
axi_chan_buffer.sv
axi_mem_slave.sv
core_axi_sys.sv
core_axi_assertions.sv
tb_core_axi_sys.sv

// File: Bender.yml
package:
  name: core_axi_bridge

# bridge_consts.svh is found through the project root include directory
export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axi_pkg.sv
      - core_mem_pkg.sv
      - core_axi_bridge.sv
      - axi_chan_buffer.sv
      - axi_mem_slave.sv
      - core_axi_sys.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_axi_assertions.sv
      - tb_core_axi_sys.sv
